/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------

   // address and register word
   localparam int XLEN = 32;
   // one bus beat
   localparam int BUS_W = 64;
   localparam int BUS_STRB_W = BUS_W / 8;
   // operation code from the issue side
   localparam int OP_W = 7;

   // access size codes kept in the load control
   localparam logic [1:0] SIZE_B = 2'd0;
   localparam logic [1:0] SIZE_H = 2'd1;
   localparam logic [1:0] SIZE_W = 2'd2;

   // --------------------------------------------------
   // vector types
   // --------------------------------------------------

   typedef logic [XLEN-1:0] addr_t;
   typedef logic [XLEN-1:0] word_t;
   typedef logic [BUS_W-1:0] bus_data_t;
   typedef logic [BUS_STRB_W-1:0] bus_strb_t;
   // byte enables inside one word
   typedef logic [XLEN/8-1:0] word_strb_t;

   // operation codes, loads in the low range and stores from 8 up
   typedef enum logic [OP_W-1:0] {
      IDLE  = 7'h00,
      LD_B  = 7'h01,
      LD_H  = 7'h02,
      LD_W  = 7'h03,
      LD_BU = 7'h04,
      LD_HU = 7'h05,
      ST_B  = 7'h09,
      ST_H  = 7'h0a,
      ST_W  = 7'h0b
   } lsu_op_t;

   // --------------------------------------------------
   // stage structs
   // --------------------------------------------------

   // one issue from the execution side
   typedef struct packed {
      lsu_op_t op;
      addr_t   base;
      addr_t   offset;
      word_t   wdata;
   } lsu_req_s;

   // what the load return path needs to narrow the data
   typedef struct packed {
      logic [1:0] size;
      logic       sign_ext;
      // address bits 2..0
      logic [2:0] shift;
   } lsu_load_ctl_s;

   // ls2 payload
   typedef struct packed {
      addr_t         addr;
      logic          is_load;
      logic          is_store;
      // already replicated over the byte lanes
      word_t         wdata;
      word_strb_t    wstrb;
      lsu_load_ctl_s ld_ctl;
   } lsu_ls2_s;

endpackage

`default_nettype wire

/* lsu_issue.sv */
`default_nettype none

module lsu_issue (
   input  wire                  clk,
   input  wire                  rst,
   // single cycle issue pulse
   input  wire                  ecl_lsu_valid_e,
   input  lsu_pkg::lsu_req_s    ecl_lsu_req_e,
   // alignment exception
   output logic                 lsu_ecl_except_ale_ls1,
   output lsu_pkg::addr_t       lsu_csr_except_badv_ls1,
   // ls2 stage
   output logic                 lsu_valid_ls2,
   output lsu_pkg::lsu_ls2_s    lsu_ls2
);

   import lsu_pkg::*;

   logic       valid_ls1;
   lsu_req_s   req_ls1;
   addr_t      addr_ls1;
   logic       is_load_ls1;
   logic       is_store_ls1;
   logic [1:0] size_ls1;
   logic       sign_ls1;
   logic       misalign_ls1;
   word_t      wdata_ls1;
   word_strb_t wstrb_ls1;
   lsu_ls2_s   ls2_d;

   // --------------------------------------------------
   // ls1 capture
   // --------------------------------------------------

   // valid follows the pulse, one cycle in ls1
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_ls1 <= 1'b0;
      end else begin
         valid_ls1 <= ecl_lsu_valid_e;
      end
   end

   // operands held until the next issue
   always_ff @(posedge clk) begin
      if (ecl_lsu_valid_e) begin
         req_ls1 <= ecl_lsu_req_e;
      end
   end

   // --------------------------------------------------
   // address and decode
   // --------------------------------------------------

   assign addr_ls1 = req_ls1.base + req_ls1.offset;

   always_comb begin
      is_load_ls1  = 1'b0;
      is_store_ls1 = 1'b0;
      size_ls1     = SIZE_W;
      sign_ls1     = 1'b0;
      case (req_ls1.op)
         LD_B: begin
            is_load_ls1 = 1'b1;
            size_ls1    = SIZE_B;
            sign_ls1    = 1'b1;
         end
         LD_H: begin
            is_load_ls1 = 1'b1;
            size_ls1    = SIZE_H;
            sign_ls1    = 1'b1;
         end
         LD_W: begin
            is_load_ls1 = 1'b1;
            sign_ls1    = 1'b1;
         end
         LD_BU: begin
            is_load_ls1 = 1'b1;
            size_ls1    = SIZE_B;
         end
         LD_HU: begin
            is_load_ls1 = 1'b1;
            size_ls1    = SIZE_H;
         end
         ST_B: begin
            is_store_ls1 = 1'b1;
            size_ls1     = SIZE_B;
         end
         ST_H: begin
            is_store_ls1 = 1'b1;
            size_ls1     = SIZE_H;
         end
         ST_W: begin
            is_store_ls1 = 1'b1;
         end
         default: begin
            // idle and unknown codes do nothing
            is_load_ls1  = 1'b0;
            is_store_ls1 = 1'b0;
         end
      endcase
   end

   // halfword on 2 bytes, word on 4 bytes
   assign misalign_ls1 = (is_load_ls1 | is_store_ls1) &
                         (((size_ls1 == SIZE_H) & addr_ls1[0]) |
                          ((size_ls1 == SIZE_W) & (addr_ls1[1:0] != 2'b00)));

   assign lsu_ecl_except_ale_ls1  = valid_ls1 & misalign_ls1;
   assign lsu_csr_except_badv_ls1 = addr_ls1;

   // --------------------------------------------------
   // store lane formatting
   // --------------------------------------------------

   // data copied to every lane, strobe picks the lane
   always_comb begin
      case (size_ls1)
         SIZE_B: begin
            wdata_ls1 = {4{req_ls1.wdata[7:0]}};
            wstrb_ls1 = 4'b0001 << addr_ls1[1:0];
         end
         SIZE_H: begin
            wdata_ls1 = {2{req_ls1.wdata[15:0]}};
            wstrb_ls1 = 4'b0011 << addr_ls1[1:0];
         end
         default: begin
            wdata_ls1 = req_ls1.wdata;
            wstrb_ls1 = 4'b1111;
         end
      endcase
   end

   always_comb begin
      ls2_d.addr            = addr_ls1;
      ls2_d.is_load         = is_load_ls1;
      ls2_d.is_store        = is_store_ls1;
      ls2_d.wdata           = wdata_ls1;
      ls2_d.wstrb           = wstrb_ls1;
      ls2_d.ld_ctl.size     = size_ls1;
      ls2_d.ld_ctl.sign_ext = sign_ls1;
      ls2_d.ld_ctl.shift    = addr_ls1[2:0];
   end

   // --------------------------------------------------
   // ls2 register
   // --------------------------------------------------

   // misaligned ops stop here, no bus request
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_valid_ls2 <= 1'b0;
      end else begin
         lsu_valid_ls2 <= valid_ls1 & (is_load_ls1 | is_store_ls1) & ~misalign_ls1;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_ls1) begin
         lsu_ls2 <= ls2_d;
      end
   end

   // core stalls while an op sits in ls1 or ls2
   a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
      ecl_lsu_valid_e |-> !(valid_ls1 || lsu_valid_ls2));

endmodule

`default_nettype wire

/* lsu_biu_req.sv */
`default_nettype none

module lsu_biu_req (
   input  wire                  clk,
   input  wire                  rst,
   input  wire                  lsu_valid_ls2,
   input  lsu_pkg::lsu_ls2_s    lsu_ls2,
   input  wire                  biu_lsu_rd_ack_ls2,
   input  wire                  biu_lsu_wr_ack_ls2,
   // read channel
   output logic                 lsu_biu_rd_req_ls2,
   output lsu_pkg::addr_t       lsu_biu_rd_addr_ls2,
   // write channel
   output logic                 lsu_biu_wr_req_ls2,
   output lsu_pkg::addr_t       lsu_biu_wr_addr_ls2,
   output lsu_pkg::bus_data_t   lsu_biu_wr_data_ls2,
   output lsu_pkg::bus_strb_t   lsu_biu_wr_strb_ls2
);

   import lsu_pkg::*;

   logic     rd_req_q;
   logic     wr_req_q;
   lsu_ls2_s pay_q;
   lsu_ls2_s pay;
   addr_t    bus_addr;

   // --------------------------------------------------
   // request hold
   // --------------------------------------------------

   // rises with ls2, held by the flop until the ack cycle
   assign lsu_biu_rd_req_ls2 = rd_req_q | (lsu_valid_ls2 & lsu_ls2.is_load);
   assign lsu_biu_wr_req_ls2 = wr_req_q | (lsu_valid_ls2 & lsu_ls2.is_store);

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_req_q <= 1'b0;
         wr_req_q <= 1'b0;
      end else begin
         // drops the cycle after the ack
         rd_req_q <= lsu_biu_rd_req_ls2 & ~biu_lsu_rd_ack_ls2;
         wr_req_q <= lsu_biu_wr_req_ls2 & ~biu_lsu_wr_ack_ls2;
      end
   end

   // payload copy for the cycles after ls2
   always_ff @(posedge clk) begin
      if (lsu_valid_ls2) begin
         pay_q <= lsu_ls2;
      end
   end

   assign pay = lsu_valid_ls2 ? lsu_ls2 : pay_q;

   // --------------------------------------------------
   // 64-bit lane placement
   // --------------------------------------------------

   // beat aligned address
   assign bus_addr = {pay.addr[XLEN-1:3], 3'b000};

   assign lsu_biu_rd_addr_ls2 = bus_addr;
   assign lsu_biu_wr_addr_ls2 = bus_addr;

   // addr bit 2 picks the upper word of the beat
   assign lsu_biu_wr_data_ls2 = pay.addr[2] ? {pay.wdata, {XLEN{1'b0}}}
                                            : {{XLEN{1'b0}}, pay.wdata};
   assign lsu_biu_wr_strb_ls2 = pay.addr[2] ? {pay.wstrb, {(XLEN/8){1'b0}}}
                                            : {{(XLEN/8){1'b0}}, pay.wstrb};

   // only one op in flight
   a_no_rd_wr: assert property (@(posedge clk) disable iff (rst)
      !(lsu_biu_rd_req_ls2 && lsu_biu_wr_req_ls2));

   // bus side never acks what was not asked
   a_rd_ack_req: assert property (@(posedge clk) disable iff (rst)
      biu_lsu_rd_ack_ls2 |-> lsu_biu_rd_req_ls2);
   a_wr_ack_req: assert property (@(posedge clk) disable iff (rst)
      biu_lsu_wr_ack_ls2 |-> lsu_biu_wr_req_ls2);

endmodule

`default_nettype wire

/* lsu_load_align.sv */
`default_nettype none

module lsu_load_align (
   input  wire                    clk,
   input  wire                    rst,
   input  wire                    lsu_valid_ls2,
   input  lsu_pkg::lsu_load_ctl_s ld_ctl,
   // bus return beat
   input  wire                    biu_lsu_data_valid_ls3,
   input  lsu_pkg::bus_data_t     biu_lsu_data_ls3,
   // result to the execution side
   output logic                   lsu_ecl_data_valid_ls3,
   output lsu_pkg::word_t         lsu_ecl_data_ls3
);

   import lsu_pkg::*;

   lsu_load_ctl_s ctl_q;
   word_t         word_sel;
   logic [7:0]    byte_sel;
   logic [15:0]   half_sel;

   // --------------------------------------------------
   // lane control
   // --------------------------------------------------

   // kept from ls2 until the beat comes back
   always_ff @(posedge clk) begin
      if (rst) begin
         ctl_q <= '0;
      end else if (lsu_valid_ls2) begin
         ctl_q <= ld_ctl;
      end
   end

   // --------------------------------------------------
   // select and extend
   // --------------------------------------------------

   // upper or lower word of the beat
   assign word_sel = ctl_q.shift[2] ? biu_lsu_data_ls3[BUS_W-1:XLEN]
                                    : biu_lsu_data_ls3[XLEN-1:0];

   always_comb begin
      case (ctl_q.shift[1:0])
         2'b00:   byte_sel = word_sel[7:0];
         2'b01:   byte_sel = word_sel[15:8];
         2'b10:   byte_sel = word_sel[23:16];
         default: byte_sel = word_sel[31:24];
      endcase
   end

   // halfword is 2-byte aligned, bit 1 is enough
   assign half_sel = ctl_q.shift[1] ? word_sel[31:16] : word_sel[15:0];

   always_comb begin
      case (ctl_q.size)
         SIZE_B: begin
            lsu_ecl_data_ls3 = {{24{ctl_q.sign_ext & byte_sel[7]}}, byte_sel};
         end
         SIZE_H: begin
            lsu_ecl_data_ls3 = {{16{ctl_q.sign_ext & half_sel[15]}}, half_sel};
         end
         default: begin
            lsu_ecl_data_ls3 = word_sel;
         end
      endcase
   end

   // data valid straight from the bus strobe
   assign lsu_ecl_data_valid_ls3 = biu_lsu_data_valid_ls3;

endmodule

`default_nettype wire

/* lsu_top.sv */
`default_nettype none

module lsu_top (
   input  wire                  clk,
   input  wire                  rst,

   // --------------------------------------------------
   // execution side
   // --------------------------------------------------
   input  wire                  ecl_lsu_valid_e,
   input  lsu_pkg::lsu_req_s    ecl_lsu_req_e,
   output logic                 lsu_ecl_data_valid_ls3,
   output lsu_pkg::word_t       lsu_ecl_data_ls3,
   output logic                 lsu_ecl_except_ale_ls1,
   output lsu_pkg::addr_t       lsu_csr_except_badv_ls1,

   // --------------------------------------------------
   // bus interface
   // --------------------------------------------------
   // read
   output logic                 lsu_biu_rd_req_ls2,
   output lsu_pkg::addr_t       lsu_biu_rd_addr_ls2,
   input  wire                  biu_lsu_rd_ack_ls2,
   input  wire                  biu_lsu_data_valid_ls3,
   input  lsu_pkg::bus_data_t   biu_lsu_data_ls3,
   // write
   output logic                 lsu_biu_wr_req_ls2,
   output lsu_pkg::addr_t       lsu_biu_wr_addr_ls2,
   output lsu_pkg::bus_data_t   lsu_biu_wr_data_ls2,
   output lsu_pkg::bus_strb_t   lsu_biu_wr_strb_ls2,
   input  wire                  biu_lsu_wr_ack_ls2
);

   import lsu_pkg::*;

   // ls2 stage shared by both back ends
   logic     lsu_valid_ls2;
   lsu_ls2_s lsu_ls2;

   // ls1 and ls2
   lsu_issue u_issue (
      .clk                     (clk),
      .rst                     (rst),
      .ecl_lsu_valid_e         (ecl_lsu_valid_e),
      .ecl_lsu_req_e           (ecl_lsu_req_e),
      .lsu_ecl_except_ale_ls1  (lsu_ecl_except_ale_ls1),
      .lsu_csr_except_badv_ls1 (lsu_csr_except_badv_ls1),
      .lsu_valid_ls2           (lsu_valid_ls2),
      .lsu_ls2                 (lsu_ls2)
   );

   // bus requests
   lsu_biu_req u_biu_req (
      .clk                 (clk),
      .rst                 (rst),
      .lsu_valid_ls2       (lsu_valid_ls2),
      .lsu_ls2             (lsu_ls2),
      .biu_lsu_rd_ack_ls2  (biu_lsu_rd_ack_ls2),
      .biu_lsu_wr_ack_ls2  (biu_lsu_wr_ack_ls2),
      .lsu_biu_rd_req_ls2  (lsu_biu_rd_req_ls2),
      .lsu_biu_rd_addr_ls2 (lsu_biu_rd_addr_ls2),
      .lsu_biu_wr_req_ls2  (lsu_biu_wr_req_ls2),
      .lsu_biu_wr_addr_ls2 (lsu_biu_wr_addr_ls2),
      .lsu_biu_wr_data_ls2 (lsu_biu_wr_data_ls2),
      .lsu_biu_wr_strb_ls2 (lsu_biu_wr_strb_ls2)
   );

   // load return
   lsu_load_align u_load_align (
      .clk                    (clk),
      .rst                    (rst),
      .lsu_valid_ls2          (lsu_valid_ls2),
      .ld_ctl                 (lsu_ls2.ld_ctl),
      .biu_lsu_data_valid_ls3 (biu_lsu_data_valid_ls3),
      .biu_lsu_data_ls3       (biu_lsu_data_ls3),
      .lsu_ecl_data_valid_ls3 (lsu_ecl_data_valid_ls3),
      .lsu_ecl_data_ls3       (lsu_ecl_data_ls3)
   );

endmodule

`default_nettype wire

/* tb_lsu_tasks.svh */
`ifndef TB_LSU_TASKS_SVH
`define TB_LSU_TASKS_SVH

// --------------------------------------------------
// checking and reference
// --------------------------------------------------

task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
   if (got !== exp) begin
      $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "stopped at the first mismatch");
   end
endtask

// little-endian bytes from the model memory narrowed and extended
function automatic word_t expected_load(input lsu_op_t op, input addr_t a);
   logic [7:0] b0;
   logic [7:0] b1;
   logic [7:0] b2;
   logic [7:0] b3;
   b0 = mem_byte(a);
   b1 = mem_byte(a + 32'd1);
   b2 = mem_byte(a + 32'd2);
   b3 = mem_byte(a + 32'd3);
   case (op)
      LD_B:    return {{24{b0[7]}}, b0};
      LD_BU:   return {24'h0, b0};
      LD_H:    return {{16{b1[7]}}, b1, b0};
      LD_HU:   return {16'h0, b1, b0};
      default: return {b3, b2, b1, b0};
   endcase
endfunction

// --------------------------------------------------
// single operations
// --------------------------------------------------

task automatic run_load(input lsu_op_t op, input addr_t base, input addr_t offset,
                        input int unsigned ack_dly);
   addr_t a;
   addr_t bus_addr;
   word_t ld_data;
   a = base + offset;
   issue_op(op, base, offset, $random(seed));
   check("alignment exception", 64'(lsu_ecl_except_ale_ls1), 64'd0);
   @(posedge clk);
   serve_bus(1'b1, ack_dly, 1 + {$random(seed)} % 3, bus_addr, ld_data);
   check("read address", 64'(bus_addr), 64'({a[31:3], 3'b000}));
   check("load data", 64'(ld_data), 64'(expected_load(op, a)));
endtask

task automatic run_store(input lsu_op_t op, input addr_t base, input addr_t offset,
                         input int unsigned ack_dly);
   addr_t      a;
   addr_t      bus_addr;
   word_t      ld_data;
   word_t      wdata;
   bus_data_t  exp_data;
   bus_strb_t  exp_strb;
   logic [1:0] sz_mask;
   logic [3:0] nb;
   logic [2:0] ln;
   int         k;
   a = base + offset;
   wdata = $random(seed);
   sz_mask = (op == ST_B) ? 2'b00 : (op == ST_H) ? 2'b01 : 2'b11;
   nb = (op == ST_B) ? 4'd1 : (op == ST_H) ? 4'd2 : 4'd4;
   issue_op(op, base, offset, wdata);
   check("alignment exception", 64'(lsu_ecl_except_ale_ls1), 64'd0);
   @(posedge clk);
   serve_bus(1'b0, ack_dly, 1, bus_addr, ld_data);
   // addressed half repeats the store bytes and the other half stays zero
   exp_data = '0;
   exp_strb = '0;
   for (k = 0; k < 8; k++) begin
      ln = 3'(k);
      if (ln[2] == a[2]) begin
         exp_data[{ln, 3'b000} +: 8] = wdata[{ln[1:0] & sz_mask, 3'b000} +: 8];
      end
      // strobes cover nb lanes from the low address bits
      if ({1'b0, ln} >= {1'b0, a[2:0]} && {1'b0, ln} < {1'b0, a[2:0]} + nb) begin
         exp_strb[ln] = 1'b1;
      end
   end
   check("write address", 64'(wr_addr_log.pop_front()), 64'({a[31:3], 3'b000}));
   check("write data", wr_data_log.pop_front(), exp_data);
   check("write strobes", 64'(wr_strb_log.pop_front()), 64'(exp_strb));
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------

task automatic idle_after_reset();
   repeat (4) begin
      @(negedge clk);
      check("idle read request", 64'(lsu_biu_rd_req_ls2), 64'd0);
      check("idle write request", 64'(lsu_biu_wr_req_ls2), 64'd0);
      check("idle load data valid", 64'(lsu_ecl_data_valid_ls3), 64'd0);
      check("idle alignment exception", 64'(lsu_ecl_except_ale_ls1), 64'd0);
   end
endtask

// every legal offset in a beat with a negative offset through the adder
task automatic load_sweep();
   lsu_op_t ops [5];
   int      k;
   int      off;
   int      step;
   ops = '{LD_B, LD_BU, LD_H, LD_HU, LD_W};
   for (k = 0; k < 5; k++) begin
      step = (ops[k] == LD_B || ops[k] == LD_BU) ? 1 : (ops[k] == LD_W) ? 4 : 2;
      for (off = 0; off < 8; off += step) begin
         run_load(ops[k], 32'h100 + 32'(8 * k), 32'hffff_ff80 + 32'(off),
                  {$random(seed)} % 4);
      end
   end
endtask

task automatic store_sweep();
   lsu_op_t ops [3];
   int      k;
   int      off;
   int      step;
   ops = '{ST_B, ST_H, ST_W};
   for (k = 0; k < 3; k++) begin
      step = (ops[k] == ST_B) ? 1 : (ops[k] == ST_H) ? 2 : 4;
      for (off = 0; off < 8; off += step) begin
         run_store(ops[k], 32'h30 + 32'(16 * k), 32'(off), {$random(seed)} % 4);
      end
   end
endtask

// exception in ls1 and then a quiet bus
task automatic misaligned_ops();
   lsu_op_t ops [6];
   addr_t   offs [6];
   int      k;
   ops = '{LD_H, LD_HU, LD_W, LD_W, ST_H, ST_W};
   offs = '{32'd1, 32'd7, 32'd2, 32'd5, 32'd3, 32'd1};
   for (k = 0; k < 6; k++) begin
      issue_op(ops[k], 32'h8000_1230, offs[k], $random(seed));
      check("alignment exception", 64'(lsu_ecl_except_ale_ls1), 64'd1);
      check("bad address", 64'(lsu_csr_except_badv_ls1), 64'(32'h8000_1230 + offs[k]));
      repeat (3) begin
         @(negedge clk);
         check("read request after exception", 64'(lsu_biu_rd_req_ls2), 64'd0);
         check("write request after exception", 64'(lsu_biu_wr_req_ls2), 64'd0);
         check("exception cleared", 64'(lsu_ecl_except_ale_ls1), 64'd0);
      end
   end
endtask

// longest ack delay with request and address checked every cycle
task automatic late_ack_ops();
   run_load(LD_W, 32'h48, 32'h4, 3);
   run_store(ST_H, 32'h60, 32'h2, 3);
endtask

`endif

/* tb_lsu.sv */
`default_nettype none

module tb_lsu;

   import lsu_pkg::*;

   localparam int CLK_PERIOD = 40;
   // loads 26, stores 14, misaligned 6, late ack 2, idle 1
   localparam int NUM_TESTS = 49;
   // longest op is well under this
   localparam int CYCLES_PER_TEST = 20;

   logic      clk;
   logic      rst;
   // execution side
   logic      ecl_lsu_valid_e;
   lsu_req_s  ecl_lsu_req_e;
   logic      lsu_ecl_data_valid_ls3;
   word_t     lsu_ecl_data_ls3;
   logic      lsu_ecl_except_ale_ls1;
   addr_t     lsu_csr_except_badv_ls1;
   // bus side
   logic      lsu_biu_rd_req_ls2;
   addr_t     lsu_biu_rd_addr_ls2;
   logic      biu_lsu_rd_ack_ls2;
   logic      biu_lsu_data_valid_ls3;
   bus_data_t biu_lsu_data_ls3;
   logic      lsu_biu_wr_req_ls2;
   addr_t     lsu_biu_wr_addr_ls2;
   bus_data_t lsu_biu_wr_data_ls2;
   bus_strb_t lsu_biu_wr_strb_ls2;
   logic      biu_lsu_wr_ack_ls2;

   integer    seed;
   int        fill_a;
   logic [7:0] fill_b;
   // 256 bytes of model memory with one entry per bus beat
   bus_data_t mem [0:31];
   // writes seen by the responder
   addr_t     wr_addr_log [$];
   bus_data_t wr_data_log [$];
   bus_strb_t wr_strb_log [$];

   lsu_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // byte at address a holds a*59 ^ 0xa7 so all 256 values differ
   initial begin
      for (fill_a = 0; fill_a < 256; fill_a++) begin
         fill_b = 8'(fill_a);
         mem[fill_b[7:3]][{fill_b[2:0], 3'b000} +: 8] = (fill_b * 8'd59) ^ 8'ha7;
      end
   end

   // --------------------------------------------------
   // bus responder model
   // --------------------------------------------------

   function automatic logic [7:0] mem_byte(input addr_t a);
      return mem[a[7:3]][{a[2:0], 3'b000} +: 8];
   endfunction

   // one-cycle issue pulse that returns at the falling edge of the ls1 cycle
   task automatic issue_op(input lsu_op_t op, input addr_t base, input addr_t offset,
                           input word_t wdata);
      @(posedge clk);
      ecl_lsu_valid_e      <= 1'b1;
      ecl_lsu_req_e.op     <= op;
      ecl_lsu_req_e.base   <= base;
      ecl_lsu_req_e.offset <= offset;
      ecl_lsu_req_e.wdata  <= wdata;
      @(posedge clk);
      ecl_lsu_valid_e <= 1'b0;
      @(negedge clk);
   endtask

   // called on the edge where the request rises
   // ack after ack_dly cycles and read data rd_lat cycles after the ack
   task automatic serve_bus(input logic is_rd, input int unsigned ack_dly,
                            input int unsigned rd_lat, output addr_t bus_addr,
                            output word_t ld_data);
      int unsigned i;
      for (i = 0; i <= ack_dly; i++) begin
         if (is_rd) begin
            biu_lsu_rd_ack_ls2 <= (i == ack_dly);
         end else begin
            biu_lsu_wr_ack_ls2 <= (i == ack_dly);
         end
         @(negedge clk);
         check("read request", 64'(lsu_biu_rd_req_ls2), 64'(is_rd));
         check("write request", 64'(lsu_biu_wr_req_ls2), 64'(!is_rd));
         check("early load data valid", 64'(lsu_ecl_data_valid_ls3), 64'd0);
         if (i == 0) begin
            bus_addr = is_rd ? lsu_biu_rd_addr_ls2 : lsu_biu_wr_addr_ls2;
         end else begin
            check("stable bus address",
                  64'(is_rd ? lsu_biu_rd_addr_ls2 : lsu_biu_wr_addr_ls2), 64'(bus_addr));
         end
         // write taken in the ack cycle
         if (!is_rd && i == ack_dly) begin
            wr_addr_log.push_back(lsu_biu_wr_addr_ls2);
            wr_data_log.push_back(lsu_biu_wr_data_ls2);
            wr_strb_log.push_back(lsu_biu_wr_strb_ls2);
         end
         @(posedge clk);
      end
      biu_lsu_rd_ack_ls2 <= 1'b0;
      biu_lsu_wr_ack_ls2 <= 1'b0;
      if (is_rd) begin
         repeat (rd_lat - 1) begin
            @(negedge clk);
            check("read request after ack", 64'(lsu_biu_rd_req_ls2), 64'd0);
            @(posedge clk);
         end
         biu_lsu_data_valid_ls3 <= 1'b1;
         biu_lsu_data_ls3       <= mem[bus_addr[7:3]];
      end
      @(negedge clk);
      check("read request after ack", 64'(lsu_biu_rd_req_ls2), 64'd0);
      check("write request after ack", 64'(lsu_biu_wr_req_ls2), 64'd0);
      check("load data valid", 64'(lsu_ecl_data_valid_ls3), 64'(is_rd));
      ld_data = lsu_ecl_data_ls3;
      @(posedge clk);
      biu_lsu_data_valid_ls3 <= 1'b0;
      biu_lsu_data_ls3       <= '0;
   endtask

   `include "tb_lsu_tasks.svh"

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      seed = 32'ha5c5;
      rst                    <= 1'b1;
      ecl_lsu_valid_e        <= 1'b0;
      ecl_lsu_req_e          <= '0;
      biu_lsu_rd_ack_ls2     <= 1'b0;
      biu_lsu_wr_ack_ls2     <= 1'b0;
      biu_lsu_data_valid_ls3 <= 1'b0;
      biu_lsu_data_ls3       <= '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      idle_after_reset();
      load_sweep();
      store_sweep();
      misaligned_ops();
      late_ack_ops();
      @(posedge clk);
      $display("=== PASS ===");
      $finish;
   end

   // watchdog
   initial begin
      repeat (NUM_TESTS * CYCLES_PER_TEST + 8) @(posedge clk);
      $display("watchdog expired, the test sequence did not finish in time");
      $display("=== FAIL ===");
      $fatal(1, "simulation timed out");
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
lsu_pkg.sv
lsu_issue.sv
lsu_biu_req.sv
lsu_load_align.sv
lsu_top.sv
tb_lsu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the lsu testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 -f src.f --top-module tb_lsu -o tb_lsu_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_lsu_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^=== PASS ===$" "$log_file"; then
   echo "simulation passed"
   exit 0
else
   echo "pass line not found in $log_file"
   exit 1
fi
